// File: design/icache_pkg.sv
package icache_pkg;

    // address and data widths
    localparam int addr_w = 32;
    localparam int word_w = 32;

    // 4-way set associative
    localparam int num_ways = 4;
    localparam int way_w = 2;

    // 128 sets, index from addr[11:5]
    localparam int num_sets = 128;
    localparam int index_w = 7;

    // eight words per line, bank from addr[4:2]
    localparam int words_per_line = 8;
    localparam int bank_w = 3;

    // byte offset within a 32-byte line
    localparam int offset_w = 5;

    // tag from addr[31:12]
    localparam int tag_w = 20;

    // controller states
    typedef enum logic [1:0] {
        lookup   = 2'd0,
        miss_req = 2'd1,
        refill   = 2'd2
    } ctrl_state_e;

endpackage

// File: design/axi_pkg.sv
package axi_pkg;

    // single outstanding read, fixed id
    localparam logic [3:0] ar_id = 4'd3;

    // one line is 8 beats
    localparam logic [7:0] ar_len_line = 8'd7;

    // 4-byte beats
    localparam logic [2:0] ar_size_word = 3'd2;

    // incrementing burst
    localparam logic [1:0] ar_burst_incr = 2'd1;

endpackage

// File: design/icache_tag_array.sv
`timescale 1ns/100ps

module icache_tag_array (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [icache_pkg::index_w-1:0]      rd_index,
    input  logic [icache_pkg::tag_w-1:0]        rd_tag,
    input  logic                                wr_en,
    input  logic [icache_pkg::way_w-1:0]        wr_way,
    input  logic [icache_pkg::index_w-1:0]      wr_index,
    input  logic [icache_pkg::tag_w-1:0]        wr_tag,
    output logic [icache_pkg::num_ways-1:0]     hit_vec,
    output logic                                init_done
);

    logic [icache_pkg::tag_w-1:0] tags [icache_pkg::num_ways][icache_pkg::num_sets];
    logic [icache_pkg::num_ways-1:0] valid_bits [icache_pkg::num_sets];
    logic [icache_pkg::index_w-1:0] sweep_index;

    // sweep counter, one set per cycle after reset
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            sweep_index <= '0;
            init_done <= 1'b0;
        end
        else if (!init_done)
        begin
            sweep_index <= sweep_index + 1'b1;
            if (sweep_index == icache_pkg::index_w'(icache_pkg::num_sets - 1))
            begin
                init_done <= 1'b1;
            end
        end
    end

    // valid bits cleared by the sweep, set by a line fill
    always_ff @(posedge clk)
    begin
        if (!init_done)
        begin
            valid_bits[sweep_index] <= '0;
        end
        else if (wr_en)
        begin
            valid_bits[wr_index][wr_way] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            tags[wr_way][wr_index] <= wr_tag;
        end
    end

    // compare all ways in parallel
    always_comb
    begin
        for (int w = 0; w < icache_pkg::num_ways; w++)
        begin
            hit_vec[w] = valid_bits[rd_index][w] && (tags[w][rd_index] == rd_tag);
        end
    end

    // a tag lives in at most one way of a set
    assert property (@(posedge clk) disable iff (rst)
        init_done |-> $onehot0(hit_vec));

endmodule

// File: design/icache_data_array.sv
`timescale 1ns/100ps

module icache_data_array (
    input  logic                                clk,
    input  logic [icache_pkg::index_w-1:0]      rd_index,
    input  logic [icache_pkg::bank_w-1:0]       rd_bank,
    input  logic [icache_pkg::num_ways-1:0]     hit_vec,
    input  logic                                wr_en,
    input  logic [icache_pkg::way_w-1:0]        wr_way,
    input  logic [icache_pkg::index_w-1:0]      wr_index,
    input  logic [icache_pkg::bank_w-1:0]       wr_bank,
    input  logic [icache_pkg::word_w-1:0]       wr_data,
    output logic [icache_pkg::word_w-1:0]       rd_data
);

    logic [icache_pkg::word_w-1:0] mem
        [icache_pkg::num_ways][icache_pkg::num_sets][icache_pkg::words_per_line];

    // one word per refill beat
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_way][wr_index][wr_bank] <= wr_data;
        end
    end

    // and-or select of the hit way
    always_comb
    begin
        rd_data = '0;
        for (int w = 0; w < icache_pkg::num_ways; w++)
        begin
            if (hit_vec[w])
            begin
                rd_data = rd_data | mem[w][rd_index][rd_bank];
            end
        end
    end

endmodule

// File: design/icache_lru.sv
`timescale 1ns/100ps

module icache_lru (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [icache_pkg::index_w-1:0]      index,
    input  logic                                hit_update,
    input  logic                                fill_update,
    input  logic [icache_pkg::way_w-1:0]        used_way,
    output logic [icache_pkg::way_w-1:0]        victim_way
);

    // position 0 is most recently used
    logic [icache_pkg::way_w-1:0] order [icache_pkg::num_sets][icache_pkg::num_ways];
    logic [icache_pkg::way_w-1:0] next_order [icache_pkg::num_ways];
    logic [icache_pkg::way_w-1:0] used_pos;

    // where the used way sits now
    always_comb
    begin
        used_pos = '0;
        for (int p = 0; p < icache_pkg::num_ways; p++)
        begin
            if (order[index][p] == used_way)
            begin
                used_pos = p[icache_pkg::way_w-1:0];
            end
        end
    end

    // move to front, shift the ones ahead of it back by one
    always_comb
    begin
        next_order[0] = used_way;
        for (int p = 1; p < icache_pkg::num_ways; p++)
        begin
            if (p <= used_pos)
            begin
                next_order[p] = order[index][p-1];
            end
            else
            begin
                next_order[p] = order[index][p];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int s = 0; s < icache_pkg::num_sets; s++)
            begin
                for (int p = 0; p < icache_pkg::num_ways; p++)
                begin
                    order[s][p] <= p[icache_pkg::way_w-1:0];
                end
            end
        end
        else if (hit_update || fill_update)
        begin
            for (int p = 0; p < icache_pkg::num_ways; p++)
            begin
                order[index][p] <= next_order[p];
            end
        end
    end

    assign victim_way = order[index][icache_pkg::num_ways-1];

endmodule

// File: design/icache_ctrl.sv
`timescale 1ns/100ps

module icache_ctrl (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                inst_req,
    input  logic [icache_pkg::addr_w-1:0]       inst_addr,
    output logic                                inst_addr_ok,
    output logic                                inst_data_ok,
    input  logic [icache_pkg::num_ways-1:0]     hit_vec,
    input  logic                                init_done,
    input  logic [icache_pkg::way_w-1:0]        victim_way,
    output logic [icache_pkg::index_w-1:0]      req_index,
    output logic [icache_pkg::tag_w-1:0]        req_tag,
    output logic [icache_pkg::bank_w-1:0]       req_bank,
    output logic                                tag_wr_en,
    output logic                                data_wr_en,
    output logic [icache_pkg::way_w-1:0]        fill_way,
    output logic [icache_pkg::bank_w-1:0]       fill_bank,
    output logic                                lru_hit_update,
    output logic                                lru_fill_update,
    output logic [icache_pkg::way_w-1:0]        used_way,
    output logic                                arvalid,
    output logic [icache_pkg::addr_w-1:0]       araddr,
    input  logic                                arready,
    input  logic                                rvalid,
    input  logic                                rlast,
    output logic                                rready
);

    icache_pkg::ctrl_state_e state;
    logic [icache_pkg::addr_w-1:0] req_addr;
    logic req_pending;
    logic hit;
    logic [icache_pkg::way_w-1:0] hit_way;
    logic [icache_pkg::bank_w-1:0] beat_cnt;
    logic take;
    logic beat;

    assign hit = |hit_vec;

    always_comb
    begin
        hit_way = '0;
        for (int w = 0; w < icache_pkg::num_ways; w++)
        begin
            if (hit_vec[w])
            begin
                hit_way = w[icache_pkg::way_w-1:0];
            end
        end
    end

    // a hit frees the slot in the same cycle
    assign inst_addr_ok = inst_req && init_done && (state == icache_pkg::lookup)
                          && (!req_pending || hit);
    assign inst_data_ok = (state == icache_pkg::lookup) && req_pending && hit;
    assign take = inst_req && inst_addr_ok;
    assign beat = (state == icache_pkg::refill) && rvalid;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            req_pending <= 1'b0;
            req_addr <= '0;
        end
        else if (take)
        begin
            req_pending <= 1'b1;
            req_addr <= inst_addr;
        end
        else if (inst_data_ok)
        begin
            req_pending <= 1'b0;
        end
    end

    assign req_index = req_addr[icache_pkg::offset_w +: icache_pkg::index_w];
    assign req_tag = req_addr[icache_pkg::offset_w + icache_pkg::index_w +: icache_pkg::tag_w];
    assign req_bank = req_addr[icache_pkg::offset_w - icache_pkg::bank_w +: icache_pkg::bank_w];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= icache_pkg::lookup;
            beat_cnt <= '0;
        end
        else
        begin
            case (state)
                icache_pkg::lookup:
                begin
                    if (init_done && req_pending && !hit)
                    begin
                        state <= icache_pkg::miss_req;
                    end
                end
                icache_pkg::miss_req:
                begin
                    if (arready)
                    begin
                        state <= icache_pkg::refill;
                        beat_cnt <= '0;
                    end
                end
                icache_pkg::refill:
                begin
                    if (rvalid)
                    begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (rlast)
                        begin
                            state <= icache_pkg::lookup;
                        end
                    end
                end
                default:
                begin
                    state <= icache_pkg::lookup;
                end
            endcase
        end
    end

    // victim held for the whole burst
    always_ff @(posedge clk)
    begin
        if ((state == icache_pkg::lookup) && req_pending && !hit)
        begin
            fill_way <= victim_way;
        end
    end

    assign fill_bank = beat_cnt;
    assign data_wr_en = beat;
    assign tag_wr_en = beat && rlast;
    assign lru_fill_update = beat && rlast;
    assign lru_hit_update = inst_data_ok;
    assign used_way = (state == icache_pkg::refill) ? fill_way : hit_way;

    assign arvalid = (state == icache_pkg::miss_req);
    assign araddr = {req_addr[icache_pkg::addr_w-1:icache_pkg::offset_w],
                     {icache_pkg::offset_w{1'b0}}};
    assign rready = (state == icache_pkg::refill);

    assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr));

    // burst must be exactly one line long
    assert property (@(posedge clk) disable iff (rst)
        rvalid && rready && rlast |-> beat_cnt == 3'd7);

endmodule

// File: design/icache_top.sv
`timescale 1ns/100ps

module icache_top (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                inst_req,
    input  logic [icache_pkg::addr_w-1:0]       inst_addr,
    output logic                                inst_addr_ok,
    output logic                                inst_data_ok,
    output logic [icache_pkg::word_w-1:0]       inst_rdata,
    output logic [3:0]                          arid,
    output logic [icache_pkg::addr_w-1:0]       araddr,
    output logic [7:0]                          arlen,
    output logic [2:0]                          arsize,
    output logic [1:0]                          arburst,
    output logic [1:0]                          arlock,
    output logic [3:0]                          arcache,
    output logic [2:0]                          arprot,
    output logic                                arvalid,
    input  logic                                arready,
    input  logic [icache_pkg::word_w-1:0]       rdata,
    input  logic                                rlast,
    input  logic                                rvalid,
    output logic                                rready
);

    logic [icache_pkg::num_ways-1:0] hit_vec;
    logic init_done;
    logic [icache_pkg::way_w-1:0] victim_way;
    logic [icache_pkg::index_w-1:0] req_index;
    logic [icache_pkg::tag_w-1:0] req_tag;
    logic [icache_pkg::bank_w-1:0] req_bank;
    logic tag_wr_en;
    logic data_wr_en;
    logic [icache_pkg::way_w-1:0] fill_way;
    logic [icache_pkg::bank_w-1:0] fill_bank;
    logic lru_hit_update;
    logic lru_fill_update;
    logic [icache_pkg::way_w-1:0] used_way;

    icache_tag_array i_tag_array (
        .clk(clk), .rst(rst), .rd_index(req_index), .rd_tag(req_tag),
        .wr_en(tag_wr_en), .wr_way(fill_way), .wr_index(req_index), .wr_tag(req_tag),
        .hit_vec(hit_vec), .init_done(init_done));

    // refill words come straight off the R channel
    icache_data_array i_data_array (
        .clk(clk), .rd_index(req_index), .rd_bank(req_bank), .hit_vec(hit_vec),
        .wr_en(data_wr_en), .wr_way(fill_way), .wr_index(req_index), .wr_bank(fill_bank),
        .wr_data(rdata), .rd_data(inst_rdata));

    icache_lru i_lru (
        .clk(clk), .rst(rst), .index(req_index), .hit_update(lru_hit_update),
        .fill_update(lru_fill_update), .used_way(used_way), .victim_way(victim_way));

    icache_ctrl i_ctrl (
        .clk(clk), .rst(rst), .inst_req(inst_req), .inst_addr(inst_addr),
        .inst_addr_ok(inst_addr_ok), .inst_data_ok(inst_data_ok), .hit_vec(hit_vec),
        .init_done(init_done), .victim_way(victim_way), .req_index(req_index),
        .req_tag(req_tag), .req_bank(req_bank), .tag_wr_en(tag_wr_en),
        .data_wr_en(data_wr_en), .fill_way(fill_way), .fill_bank(fill_bank),
        .lru_hit_update(lru_hit_update), .lru_fill_update(lru_fill_update),
        .used_way(used_way), .arvalid(arvalid), .araddr(araddr), .arready(arready),
        .rvalid(rvalid), .rlast(rlast), .rready(rready));

    // fixed AR fields, always a full-line incrementing burst
    assign arid = axi_pkg::ar_id;
    assign arlen = axi_pkg::ar_len_line;
    assign arsize = axi_pkg::ar_size_word;
    assign arburst = axi_pkg::ar_burst_incr;
    assign arlock = 2'b00;
    assign arcache = 4'b0000;
    assign arprot = 3'b000;

endmodule

// File: verif/axi_mem_model.sv
`timescale 1ns/100ps

module axi_mem_model (
    input  logic        clk,
    input  logic        rst,
    input  logic        arvalid,
    input  logic [31:0] araddr,
    output logic        arready,
    output logic        rvalid,
    output logic [31:0] rdata,
    output logic        rlast,
    input  logic        rready
);

    logic [31:0] rng;
    logic [31:0] line_addr;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // stall of 0 to 3 cycles
    task automatic draw_stall(output int cycles);
        rng = xorshift32(rng);
        cycles = int'(rng[1:0]);
    endtask

    // outputs change on the falling edge only
    initial
    begin
        int stall;
        rng = 32'h9bf8_5231;
        arready = 1'b0;
        rvalid = 1'b0;
        rdata = '0;
        rlast = 1'b0;
        forever
        begin
            @(negedge clk);
            if (!rst && arvalid)
            begin
                draw_stall(stall);
                repeat (stall) @(negedge clk);
                line_addr = araddr;
                arready = 1'b1;
                @(negedge clk);
                arready = 1'b0;
                for (int k = 0; k < 8; k++)
                begin
                    draw_stall(stall);
                    repeat (stall) @(negedge clk);
                    rvalid = 1'b1;
                    // word content is its own byte address, scrambled
                    rdata = (line_addr + 32'(4 * k)) ^ 32'h5a5a_0000;
                    rlast = (k == 7);
                    while (!rready)
                    begin
                        @(negedge clk);
                    end
                    @(negedge clk);
                    rvalid = 1'b0;
                    rlast = 1'b0;
                end
            end
        end
    end

endmodule

// File: verif/icache_tb.sv
`timescale 1ns/100ps

module icache_tb;

    typedef logic [3:0][1:0] order_t;

    logic clk;
    logic rst;
    logic inst_req;
    logic [31:0] inst_addr;
    logic inst_addr_ok;
    logic inst_data_ok;
    logic [31:0] inst_rdata;
    logic [3:0] arid;
    logic [31:0] araddr;
    logic [7:0] arlen;
    logic [2:0] arsize;
    logic [1:0] arburst;
    logic [1:0] arlock;
    logic [3:0] arcache;
    logic [2:0] arprot;
    logic arvalid;
    logic arready;
    logic [31:0] rdata;
    logic rlast;
    logic rvalid;
    logic rready;

    // reference model of tags, valid bits and recency order
    logic [19:0] m_tag [128][4];
    logic [3:0] m_valid [128];
    order_t m_order [128];
    logic predict_hit;
    logic [1:0] m_hit_way;

    logic took;
    logic hit_d1;
    logic miss_d1;
    logic miss_d2;
    logic last_d1;
    logic outstanding;
    logic [31:0] pend_addr;
    logic [31:0] araddr_q;
    int since_rst;
    int beats_seen;
    int ar_total;
    int miss_total;
    int cycles;

    wire take = inst_req && inst_addr_ok;
    wire [6:0] m_set = inst_addr[11:5];
    wire [31:0] exp_rdata = {pend_addr[31:2], 2'b00} ^ 32'h5a5a_0000;
    wire [31:0] exp_line = {pend_addr[31:5], 5'b0};

    icache_top i_dut (.*);

    axi_mem_model i_mem (.*);

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #20 clk = ~clk;
        end
    end

    task automatic value_error(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        $display("ERROR at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic plain_error(input string what);
        $display("%0t ns: %s", $time, what);
        $display("Finished with errors");
        $fatal(1);
    endtask

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles == 4000)
        begin
            plain_error("timeout, the access sequence did not finish within 4000 cycles");
        end
    end

    // used way to the front, the ones ahead of it slide back
    function automatic order_t move_to_front(input order_t ord, input logic [1:0] way);
        order_t res;
        int pos;
        pos = 0;
        for (int p = 0; p < 4; p++)
        begin
            if (ord[p] == way)
            begin
                pos = p;
            end
        end
        res = ord;
        for (int p = 1; p <= pos; p++)
        begin
            res[p] = ord[p - 1];
        end
        res[0] = way;
        return res;
    endfunction

    always_comb
    begin
        predict_hit = 1'b0;
        m_hit_way = '0;
        for (int w = 0; w < 4; w++)
        begin
            if (m_valid[m_set][w] && m_tag[m_set][w] == inst_addr[31:12])
            begin
                predict_hit = 1'b1;
                m_hit_way = w[1:0];
            end
        end
    end

    always @(posedge clk)
    begin
        if (rst)
        begin
            for (int s = 0; s < 128; s++)
            begin
                m_valid[s] <= '0;
                m_order[s] <= {2'd3, 2'd2, 2'd1, 2'd0};
            end
        end
        else if (take && predict_hit)
        begin
            m_order[m_set] <= move_to_front(m_order[m_set], m_hit_way);
        end
        else if (take)
        begin
            // miss replaces the least recently used way
            m_tag[m_set][m_order[m_set][3]] <= inst_addr[31:12];
            m_valid[m_set][m_order[m_set][3]] <= 1'b1;
            m_order[m_set] <= move_to_front(m_order[m_set], m_order[m_set][3]);
        end
    end

    always @(posedge clk)
    begin
        took <= take;
        hit_d1 <= take && predict_hit;
        miss_d1 <= take && !predict_hit;
        miss_d2 <= miss_d1;
        last_d1 <= rvalid && rready && rlast;
        araddr_q <= araddr;
        since_rst <= rst ? 0 : since_rst + 1;
        if (rst)
        begin
            outstanding <= 1'b0;
        end
        else if (take)
        begin
            pend_addr <= inst_addr;
            outstanding <= 1'b1;
            miss_total <= miss_total + (predict_hit ? 0 : 1);
        end
        else if (inst_data_ok)
        begin
            outstanding <= 1'b0;
        end
        if (arvalid && arready)
        begin
            ar_total <= ar_total + 1;
            beats_seen <= 0;
        end
        else if (rvalid && rready)
        begin
            beats_seen <= beats_seen + 1;
        end
    end

    // bus stays quiet during the valid sweep
    assert property (@(posedge clk) disable iff (rst)
        since_rst < 128 |-> {inst_addr_ok, inst_data_ok, arvalid, rready} == 4'b0)
    else value_error("addr_ok/data_ok/arvalid/rready", 0,
                     $sampled({inst_addr_ok, inst_data_ok, arvalid, rready}));

    assert property (@(posedge clk) disable iff (rst)
        inst_data_ok |-> inst_rdata == exp_rdata)
    else value_error("inst_rdata", $sampled(exp_rdata), $sampled(inst_rdata));

    // one cycle after a hit or after the rlast beat, never otherwise
    assert property (@(posedge clk) disable iff (rst)
        inst_data_ok == (hit_d1 || last_d1))
    else value_error("inst_data_ok", $sampled(hit_d1 || last_d1), $sampled(inst_data_ok));

    assert property (@(posedge clk) disable iff (rst) $rose(arvalid) == miss_d2)
    else value_error("arvalid rise", $sampled(miss_d2), $sampled(arvalid));

    assert property (@(posedge clk) disable iff (rst)
        arvalid |-> {araddr, arlen, arsize, arburst} == {exp_line, 8'd7, 3'd2, 2'd1})
    else value_error("araddr/arlen/arsize/arburst", $sampled({exp_line, 8'd7, 3'd2, 2'd1}),
                     $sampled({araddr, arlen, arsize, arburst}));

    // fixed id, no lock, cache or protection attributes
    assert property (@(posedge clk) disable iff (rst)
        arvalid |-> {arid, arlock, arcache, arprot} == {4'd3, 2'd0, 4'd0, 3'd0})
    else value_error("arid/arlock/arcache/arprot", {4'd3, 2'd0, 4'd0, 3'd0},
                     $sampled({arid, arlock, arcache, arprot}));

    assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && araddr == araddr_q)
    else value_error("arvalid/araddr", $sampled({1'b1, araddr_q}), $sampled({arvalid, araddr}));

    assert property (@(posedge clk) disable iff (rst) arvalid && arready |=> !arvalid)
    else value_error("arvalid", 0, 1);

    // refill ends only after all eight beats
    assert property (@(posedge clk) disable iff (rst)
        $fell(rready) |-> beats_seen == 8)
    else value_error("beats per refill", 8, $sampled(beats_seen));

    task automatic fetch(input logic [31:0] addr);
        inst_req = 1'b1;
        inst_addr = addr;
        @(negedge clk);
        while (!took)
        begin
            @(negedge clk);
        end
        inst_req = 1'b0;
    endtask

    task automatic wait_idle();
        while (outstanding)
        begin
            @(negedge clk);
        end
    endtask

    initial
    begin
        rst = 1'b1;
        inst_req = 1'b0;
        inst_addr = '0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        // same set, tags A B C D A E B A
        fetch(32'h1000_00a4);
        fetch(32'h2000_00a8);
        fetch(32'h3000_00ac);
        fetch(32'h4000_00b0);
        fetch(32'h1000_00b8);
        fetch(32'h5000_00bc);
        fetch(32'h2000_00a0);
        fetch(32'h1000_00a0);
        wait_idle();
        assert (ar_total == 6)
        else plain_error("same-set sequence did not issue exactly six AR bursts");
        // one line word by word, then the same words back to back as hits
        for (int k = 0; k < 16; k++)
        begin
            fetch(32'h0000_3400 + 32'(4 * (k % 8)));
        end
        fetch(32'h4000_00a4);
        fetch(32'h5000_00a0);
        fetch(32'h2000_00b4);
        fetch(32'h1000_00ac);
        wait_idle();
        if (ar_total != miss_total)
        begin
            plain_error("number of AR bursts differs from the predicted misses");
        end
        else
        begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

// File: build.f
design/icache_pkg.sv
design/axi_pkg.sv
design/icache_tag_array.sv
design/icache_data_array.sv
design/icache_lru.sv
design/icache_ctrl.sv
design/icache_top.sv
verif/axi_mem_model.sv
verif/icache_tb.sv
